// ==== design/tdd_pkg.sv ====
/*
  Shared types and constants of the TDD controller register map.
  Eight channels with 32-bit timing registers are built. The widths are
  fixed here and the address map covers exactly eight channels.
*/
`default_nettype none

package tdd_pkg;

  // ************************************************************************
  // widths and constant words
  // ************************************************************************

  localparam int channel_count  = 8;
  localparam int reg_width      = 32;
  localparam int addr_width     = 8;
  localparam int data_width     = 32;
  localparam int ch_index_width = $clog2(channel_count);

  localparam logic [data_width-1:0]    core_version     = 32'h0002_0100;
  localparam logic [data_width-1:0]    core_magic       = 32'h5444_4443;
  localparam logic [channel_count-1:0] default_polarity = 8'h00;

  // reg_width, internal sync present, channel count minus one
  localparam logic [data_width-1:0] interface_word = {16'h0000, 8'(reg_width),
                                                      2'b00, 1'b1,
                                                      5'(channel_count - 1)};

  // register addresses
  typedef enum logic [addr_width-1:0] {
    addr_version       = 8'h00,
    addr_scratch       = 8'h02,
    addr_identification = 8'h03,
    addr_interface     = 8'h04,
    addr_def_polarity  = 8'h05,
    addr_control       = 8'h10,
    addr_ch_enable     = 8'h11,
    addr_ch_polarity   = 8'h12,
    addr_burst_count   = 8'h13,
    addr_startup_delay = 8'h14,
    addr_frame_length  = 8'h15,
    addr_sync_period   = 8'h16,
    addr_status        = 8'h18,
    addr_ch_base       = 8'h20
  } tdd_addr_e;

  // on time at base + 2i, off time at base + 2i + 1
  localparam logic [addr_width-1:0] ch_last_addr = 8'h2F;

  // timing engine state, reported through the status register
  typedef enum logic [1:0] {
    state_idle,
    state_armed,
    state_running,
    state_waiting
  } tdd_state_e;

  // ************************************************************************
  // packed structs
  // ************************************************************************

  // bit 0 is enable, bit 3 is a spare that reads 0
  typedef struct packed {
    logic sync_soft;
    logic spare;
    logic sync_int;
    logic sync_rst;
    logic enable;
  } tdd_ctrl_t;

  typedef struct packed {
    logic [channel_count-1:0] ch_en;
    logic [channel_count-1:0] ch_pol;
    logic [reg_width-1:0]     burst_count;
    logic [reg_width-1:0]     startup_delay;
    logic [reg_width-1:0]     frame_length;
    logic [31:0]              sync_period;
  } tdd_cfg_t;

  typedef struct packed {
    logic                  req;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] data;
  } bus_wr_t;

  typedef struct packed {
    logic                  req;
    logic [addr_width-1:0] addr;
  } bus_rd_t;

  typedef struct packed {
    logic                      valid;
    logic [ch_index_width-1:0] index;
    logic                      off_sel;
    logic [reg_width-1:0]      data;
  } ch_wr_t;

  typedef logic [channel_count-1:0][reg_width-1:0] ch_times_t;

endpackage

`default_nettype wire

// ==== design/tdd_ctrl_regs.sv ====
/*
  Write side of the register map. Every write is acknowledged one cycle
  later, there is no back-pressure. Configuration and channel times are
  locked while the registered enable is high; ch_enable is never locked.
  The channel strobe is combinational and valid in the request cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module tdd_ctrl_regs (
  input  logic                                up_clk,
  input  logic                                up_rstn,
  input  tdd_pkg::bus_wr_t                    wr,
  output logic                                wack,
  output tdd_pkg::tdd_ctrl_t                  ctrl,
  output tdd_pkg::tdd_cfg_t                   cfg,
  output logic [tdd_pkg::data_width-1:0]      scratch,
  output tdd_pkg::ch_wr_t                     ch_wr
);

  import tdd_pkg::*;

  logic                  wr_lockable;
  logic                  wr_ch_range;
  logic [addr_width-1:0] ch_offset;

  // writes to locked registers only pass with the engine disabled
  assign wr_lockable = wr.req & ~ctrl.enable;

  assign wr_ch_range = (wr.addr >= addr_ch_base) && (wr.addr <= ch_last_addr);
  assign ch_offset   = wr.addr - addr_ch_base;

  // ************************************************************************
  // control, scratch and configuration
  // ************************************************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      wack    <= 1'b0;
      scratch <= '0;
      ctrl    <= '0;
      cfg     <= '0;
      cfg.ch_pol <= default_polarity;
    end else begin
      wack <= wr.req;
      // soft sync is a single-cycle pulse
      ctrl.sync_soft <= 1'b0;
      if (wr.req) begin
        case (wr.addr)
          addr_scratch: scratch <= wr.data;
          addr_control: begin
            ctrl.sync_soft <= wr.data[4];
            ctrl.sync_int  <= wr.data[2];
            ctrl.sync_rst  <= wr.data[1];
            ctrl.enable    <= wr.data[0];
          end
          addr_ch_enable: cfg.ch_en <= wr.data[channel_count-1:0];
          default: ;
        endcase
      end
      if (wr_lockable) begin
        case (wr.addr)
          addr_ch_polarity:   cfg.ch_pol        <= wr.data[channel_count-1:0];
          addr_burst_count:   cfg.burst_count   <= wr.data[reg_width-1:0];
          addr_startup_delay: cfg.startup_delay <= wr.data[reg_width-1:0];
          addr_frame_length:  cfg.frame_length  <= wr.data[reg_width-1:0];
          addr_sync_period:   cfg.sync_period   <= wr.data[31:0];
          default: ;
        endcase
      end
    end
  end

  // ************************************************************************
  // channel write strobe
  // ************************************************************************

  // odd offsets select the off time
  always_comb begin
    ch_wr.valid   = wr_lockable & wr_ch_range;
    ch_wr.index   = ch_offset[ch_index_width:1];
    ch_wr.off_sel = ch_offset[0];
    ch_wr.data    = wr.data[reg_width-1:0];
  end

endmodule

`default_nettype wire

// ==== design/tdd_channel_bank.sv ====
/*
  Per-channel on and off times. An entry loads on the clock edge that
  ends a valid strobe. The lock is applied upstream and not here.
*/
`timescale 1ns/1ps
`default_nettype none

module tdd_channel_bank (
  input  logic                up_clk,
  input  logic                up_rstn,
  input  tdd_pkg::ch_wr_t     ch_wr,
  output tdd_pkg::ch_times_t  ch_on,
  output tdd_pkg::ch_times_t  ch_off
);

  import tdd_pkg::*;

  logic on_load;
  logic off_load;

  assign on_load  = ch_wr.valid & ~ch_wr.off_sel;
  assign off_load = ch_wr.valid &  ch_wr.off_sel;

  // on times
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      ch_on <= '0;
    end else if (on_load) begin
      ch_on[ch_wr.index] <= ch_wr.data;
    end
  end

  // off times
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      ch_off <= '0;
    end else if (off_load) begin
      ch_off[ch_wr.index] <= ch_wr.data;
    end
  end

endmodule

`default_nettype wire

// ==== design/tdd_read_mux.sv ====
/*
  Read side of the register map. rdata and rack arrive one cycle after
  the read request; rdata is zero in every other cycle.
  Unmapped addresses read zero, narrow fields are zero-extended.
*/
`timescale 1ns/1ps
`default_nettype none

module tdd_read_mux (
  input  logic                            up_clk,
  input  logic                            up_rstn,
  input  tdd_pkg::bus_rd_t                rd,
  input  tdd_pkg::tdd_ctrl_t              ctrl,
  input  tdd_pkg::tdd_cfg_t               cfg,
  input  logic [tdd_pkg::data_width-1:0]  scratch,
  input  tdd_pkg::tdd_state_e             tdd_state,
  input  tdd_pkg::ch_times_t              ch_on,
  input  tdd_pkg::ch_times_t              ch_off,
  output logic [tdd_pkg::data_width-1:0]  rdata,
  output logic                            rack
);

  import tdd_pkg::*;

  localparam int pad_ch   = data_width - channel_count;
  localparam int pad_ctrl = data_width - $bits(tdd_ctrl_t);

  logic                      rd_ch_range;
  logic [addr_width-1:0]     ch_offset;
  logic [ch_index_width-1:0] ch_index;
  logic [data_width-1:0]     rdata_d;

  assign rd_ch_range = (rd.addr >= addr_ch_base) && (rd.addr <= ch_last_addr);
  assign ch_offset   = rd.addr - addr_ch_base;
  assign ch_index    = ch_offset[ch_index_width:1];

  // ************************************************************************
  // address decode
  // ************************************************************************

  always_comb begin
    rdata_d = '0;
    if (rd_ch_range) begin
      rdata_d = ch_offset[0] ? ch_off[ch_index] : ch_on[ch_index];
    end else begin
      case (rd.addr)
        addr_version:        rdata_d = core_version;
        addr_scratch:        rdata_d = scratch;
        addr_identification: rdata_d = core_magic;
        addr_interface:      rdata_d = interface_word;
        addr_def_polarity:   rdata_d = {{pad_ch{1'b0}}, default_polarity};
        addr_control:        rdata_d = {{pad_ctrl{1'b0}}, ctrl};
        addr_ch_enable:      rdata_d = {{pad_ch{1'b0}}, cfg.ch_en};
        addr_ch_polarity:    rdata_d = {{pad_ch{1'b0}}, cfg.ch_pol};
        addr_burst_count:    rdata_d = cfg.burst_count;
        addr_startup_delay:  rdata_d = cfg.startup_delay;
        addr_frame_length:   rdata_d = cfg.frame_length;
        addr_sync_period:    rdata_d = cfg.sync_period;
        addr_status:         rdata_d = {{(data_width-2){1'b0}}, tdd_state};
        default:             rdata_d = '0;
      endcase
    end
  end

  // registered response with data only alongside rack
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      rack  <= 1'b0;
      rdata <= '0;
    end else begin
      rack  <= rd.req;
      rdata <= rd.req ? rdata_d : '0;
    end
  end

endmodule

`default_nettype wire

// ==== design/tdd_regmap.sv ====
/*
  Register map of the TDD timing controller, single clock domain.
  Requests are always accepted and acknowledged one cycle later.
  The timing engine state comes in from outside for the status read.
*/
`timescale 1ns/1ps
`default_nettype none

module tdd_regmap (
  input  logic                            up_clk,
  input  logic                            up_rstn,
  input  tdd_pkg::bus_wr_t                wr,
  output logic                            wack,
  input  tdd_pkg::bus_rd_t                rd,
  output logic [tdd_pkg::data_width-1:0]  rdata,
  output logic                            rack,
  input  tdd_pkg::tdd_state_e             tdd_state,
  output tdd_pkg::tdd_ctrl_t              ctrl,
  output tdd_pkg::tdd_cfg_t               cfg,
  output tdd_pkg::ch_times_t              ch_on,
  output tdd_pkg::ch_times_t              ch_off
);

  import tdd_pkg::*;

  logic [data_width-1:0] scratch;
  ch_wr_t                ch_wr;

  // write decode, control and locked configuration
  tdd_ctrl_regs i_ctrl_regs (
    .up_clk  (up_clk),
    .up_rstn (up_rstn),
    .wr      (wr),
    .wack    (wack),
    .ctrl    (ctrl),
    .cfg     (cfg),
    .scratch (scratch),
    .ch_wr   (ch_wr)
  );

  tdd_channel_bank i_channel_bank (
    .up_clk  (up_clk),
    .up_rstn (up_rstn),
    .ch_wr   (ch_wr),
    .ch_on   (ch_on),
    .ch_off  (ch_off)
  );

  tdd_read_mux i_read_mux (
    .up_clk    (up_clk),
    .up_rstn   (up_rstn),
    .rd        (rd),
    .ctrl      (ctrl),
    .cfg       (cfg),
    .scratch   (scratch),
    .tdd_state (tdd_state),
    .ch_on     (ch_on),
    .ch_off    (ch_off),
    .rdata     (rdata),
    .rack      (rack)
  );

endmodule

`default_nettype wire

// ==== tests/tdd_regmap_asserts.sv ====
/*
  Handshake and soft-sync properties of the register map.
  Checked only while up_rstn is high.
*/
`timescale 1ns/1ps
`default_nettype none

module tdd_regmap_asserts (
  input logic                            up_clk,
  input logic                            up_rstn,
  input tdd_pkg::bus_wr_t                wr,
  input tdd_pkg::bus_rd_t                rd,
  input logic                            wack,
  input logic                            rack,
  input logic [tdd_pkg::data_width-1:0]  rdata,
  input tdd_pkg::tdd_ctrl_t              ctrl
);

  a_wack_latency: assert property (@(posedge up_clk) disable iff (!up_rstn)
    wack == $past(wr.req)) else $error("wack does not follow the write request");

  a_rack_latency: assert property (@(posedge up_clk) disable iff (!up_rstn)
    rack == $past(rd.req)) else $error("rack does not follow the read request");

  // read data bus is quiet between acknowledges
  a_rdata_idle: assert property (@(posedge up_clk) disable iff (!up_rstn)
    !rack |-> rdata == '0) else $error("rdata is nonzero without rack");

  a_soft_pulse: assert property (@(posedge up_clk) disable iff (!up_rstn)
    ctrl.sync_soft |=> !ctrl.sync_soft) else $error("sync_soft lasts two cycles");

endmodule

bind tdd_regmap tdd_regmap_asserts i_asserts (
  .up_clk  (up_clk),
  .up_rstn (up_rstn),
  .wr      (wr),
  .rd      (rd),
  .wack    (wack),
  .rack    (rack),
  .rdata   (rdata),
  .ctrl    (ctrl)
);

`default_nettype wire

// ==== tests/tdd_regmap_tb.sv ====
/*
  Testbench of the TDD register map. A shadow model follows every write
  and predicts each read; reads are checked in acknowledge order.
  Inputs change 0.5 ns after the rising edge, outputs are sampled after it.
*/
`timescale 1ns/1ps
`default_nettype none

module tdd_regmap_tb;

  import tdd_pkg::*;

  localparam int test_cycles = 1500;
  localparam int max_cycles  = 2 * test_cycles + 1000;
  localparam int ack_limit   = 8;

  logic                  up_clk;
  logic                  up_rstn;
  bus_wr_t               wr;
  bus_rd_t               rd;
  logic                  wack;
  logic                  rack;
  logic [data_width-1:0] rdata;
  tdd_state_e            tdd_state;
  tdd_ctrl_t             ctrl;
  tdd_cfg_t              cfg;
  ch_times_t             ch_on;
  ch_times_t             ch_off;

  int seed = 26169;
  int errors;
  int cycle_count;

  // shadow model of the register contents
  logic [data_width-1:0] exp_scratch;
  logic                  exp_enable;
  logic                  exp_sync_rst;
  logic                  exp_sync_int;
  tdd_cfg_t              exp_cfg;
  ch_times_t             exp_on;
  ch_times_t             exp_off;

  // pending reads with the oldest first
  logic [data_width-1:0] exp_q[$];
  logic [addr_width-1:0] addr_q[$];
  logic [data_width-1:0] pop_data;
  logic [addr_width-1:0] pop_addr;

  tdd_regmap tdd_regmap_i (
    .up_clk    (up_clk),
    .up_rstn   (up_rstn),
    .wr        (wr),
    .wack      (wack),
    .rd        (rd),
    .rdata     (rdata),
    .rack      (rack),
    .tdd_state (tdd_state),
    .ctrl      (ctrl),
    .cfg       (cfg),
    .ch_on     (ch_on),
    .ch_off    (ch_off)
  );

  always #2 up_clk = ~up_clk;

  // ************************************************************************
  // checks and reference model
  // ************************************************************************

  task automatic check_value(input logic [255:0] got, input logic [255:0] exp,
                             input string msg);
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  task automatic reset_model();
    exp_scratch   = '0;
    exp_enable    = 1'b0;
    exp_sync_rst  = 1'b0;
    exp_sync_int  = 1'b0;
    exp_cfg       = '0;
    exp_cfg.ch_pol = default_polarity;
    exp_on        = '0;
    exp_off       = '0;
  endtask

  task automatic update_model(input logic [7:0] addr, input logic [31:0] data);
    logic [7:0] offset;
    logic       locked;
    locked = exp_enable;
    offset = addr - 8'h20;
    if (addr >= 8'h20 && addr <= 8'h2F) begin
      if (!locked && offset[0])
        exp_off[offset[3:1]] = data;
      else if (!locked)
        exp_on[offset[3:1]] = data;
    end else begin
      case (addr)
        addr_scratch: exp_scratch = data;
        addr_control: {exp_sync_int, exp_sync_rst, exp_enable} = data[2:0];
        addr_ch_enable: exp_cfg.ch_en = data[7:0];
        addr_ch_polarity: if (!locked) exp_cfg.ch_pol = data[7:0];
        addr_burst_count: if (!locked) exp_cfg.burst_count = data;
        addr_startup_delay: if (!locked) exp_cfg.startup_delay = data;
        addr_frame_length: if (!locked) exp_cfg.frame_length = data;
        addr_sync_period: if (!locked) exp_cfg.sync_period = data;
        default: ;
      endcase
    end
  endtask

  function automatic logic [31:0] expected_read(input logic [7:0] addr);
    logic [7:0]  offset;
    logic [31:0] value;
    offset = addr - 8'h20;
    value  = '0;
    if (addr >= 8'h20 && addr <= 8'h2F) begin
      value = offset[0] ? exp_off[offset[3:1]] : exp_on[offset[3:1]];
    end else begin
      case (addr)
        addr_version:        value = core_version;
        addr_scratch:        value = exp_scratch;
        addr_identification: value = "TDDC";
        addr_interface:      value = (32'(reg_width) << 8) | 32'h20 | 32'(channel_count - 1);
        addr_def_polarity:   value = 32'(default_polarity);
        addr_control:        value = {29'b0, exp_sync_int, exp_sync_rst, exp_enable};
        addr_ch_enable:      value = 32'(exp_cfg.ch_en);
        addr_ch_polarity:    value = 32'(exp_cfg.ch_pol);
        addr_burst_count:    value = exp_cfg.burst_count;
        addr_startup_delay:  value = exp_cfg.startup_delay;
        addr_frame_length:   value = exp_cfg.frame_length;
        addr_sync_period:    value = exp_cfg.sync_period;
        addr_status:         value = 32'(tdd_state);
        default:             value = '0;
      endcase
    end
    return value;
  endfunction

  task automatic check_outputs(input string tag);
    check_value(256'(cfg), 256'(exp_cfg), {tag, ": cfg"});
    check_value(256'(ch_on), 256'(exp_on), {tag, ": ch_on"});
    check_value(256'(ch_off), 256'(exp_off), {tag, ": ch_off"});
    check_value(256'({ctrl.spare, ctrl.sync_int, ctrl.sync_rst, ctrl.enable}),
                256'({1'b0, exp_sync_int, exp_sync_rst, exp_enable}), {tag, ": ctrl"});
  endtask

  // ************************************************************************
  // bus tasks enter and leave 0.5 ns after a rising edge
  // ************************************************************************

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    int waited;
    wr.req  = 1'b1;
    wr.addr = addr;
    wr.data = data;
    @(posedge up_clk);
    #0.5;
    wr.req = 1'b0;
    waited = 1;
    while (!wack && waited < ack_limit) begin
      @(posedge up_clk);
      #0.5;
      waited++;
    end
    if (!wack) begin
      errors++;
      $display("write to address %02h was never acknowledged", addr);
    end else begin
      check_value(256'(waited), 256'(1), "write acknowledge latency");
    end
    update_model(addr, data);
  endtask

  task automatic issue_read(input logic [7:0] addr);
    rd.req  = 1'b1;
    rd.addr = addr;
    exp_q.push_back(expected_read(addr));
    addr_q.push_back(addr);
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
    int waited;
    issue_read(addr);
    @(posedge up_clk);
    #0.5;
    rd.req = 1'b0;
    waited = 1;
    while (!rack && waited < ack_limit) begin
      @(posedge up_clk);
      #0.5;
      waited++;
    end
    if (!rack) begin
      errors++;
      $display("read of address %02h was never acknowledged", addr);
    end else begin
      check_value(256'(waited), 256'(1), "read acknowledge latency");
    end
    data = rdata;
  endtask

  task automatic wait_reads();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < ack_limit) begin
      @(posedge up_clk);
      #0.5;
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d read responses never arrived", exp_q.size());
    end
  endtask

  // one read per cycle with the request held high
  task automatic read_burst(input int count);
    logic [31:0] r;
    for (int i = 0; i < count; i++) begin
      r = $random(seed);
      issue_read({2'b00, r[5:0] % 6'd48});
      @(posedge up_clk);
      #0.5;
    end
    rd.req = 1'b0;
    wait_reads();
  endtask

  task automatic read_all();
    logic [31:0] data;
    for (int a = 0; a <= 'h2F; a++)
      read_reg(8'(a), data);
  endtask

  task automatic write_and_read(input logic [7:0] addr);
    logic [31:0] data;
    data = $random(seed);
    write_reg(addr, data);
    read_reg(addr, data);
  endtask

  task automatic write_config_random();
    write_and_read(addr_scratch);
    write_and_read(addr_ch_enable);
    write_and_read(addr_ch_polarity);
    write_and_read(addr_burst_count);
    write_and_read(addr_startup_delay);
    write_and_read(addr_frame_length);
    write_and_read(addr_sync_period);
  endtask

  task automatic write_channels_random();
    for (int a = 'h20; a <= 'h2F; a++)
      write_and_read(8'(a));
  endtask

  task automatic end_run();
    $display("tests finished with %0d errors", errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  endtask

  // ************************************************************************
  // processes
  // ************************************************************************

  // compares every acknowledged read against the queued prediction
  initial begin
    forever begin
      @(negedge up_clk);
      if (up_rstn && rack && exp_q.size() == 0) begin
        errors++;
        $display("read acknowledge without a pending read");
      end else if (up_rstn && rack) begin
        pop_data = exp_q.pop_front();
        pop_addr = addr_q.pop_front();
        check_value(256'(rdata), 256'(pop_data), $sformatf("read of address %02h", pop_addr));
      end else if (up_rstn) begin
        check_value(256'(rdata), 256'(0), "rdata without rack");
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < max_cycles) begin
      @(posedge up_clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", max_cycles);
    errors++;
    end_run();
  end

  initial begin : main
    logic [31:0] data;
    up_clk    = 1'b0;
    up_rstn   = 1'b0;
    wr        = '0;
    rd        = '0;
    tdd_state = state_idle;
    errors    = 0;
    reset_model();
    repeat (10) @(posedge up_clk);
    #0.5;
    up_rstn = 1'b1;
    check_outputs("after reset");
    read_all();

    for (int round = 0; round < 8; round++)
      write_config_random();
    for (int round = 0; round < 4; round++)
      write_channels_random();
    check_outputs("unlocked writes");

    // enable locks configuration and channel times
    write_reg(addr_control, 32'h1);
    write_config_random();
    write_channels_random();
    check_outputs("locked writes");
    read_all();
    write_reg(addr_control, 32'h0);
    write_config_random();
    write_channels_random();
    check_outputs("after unlock");

    check_value(256'(ctrl.sync_soft), 256'(0), "sync_soft before control write");
    write_reg(addr_control, 32'h17);
    check_value(256'(ctrl.sync_soft), 256'(1), "sync_soft pulse");
    @(posedge up_clk);
    #0.5;
    check_value(256'(ctrl.sync_soft), 256'(0), "sync_soft one cycle later");
    read_reg(addr_control, data);
    check_value(256'(data[4]), 256'(0), "control bit 4 on read");
    check_outputs("soft sync");
    write_reg(addr_control, 32'h0);

    for (int s = 0; s < 4; s++) begin
      tdd_state = tdd_state_e'(2'(s));
      read_reg(addr_status, data);
    end
    tdd_state = state_idle;

    read_burst(64);
    wait_reads();
    end_run();
  end

endmodule

`default_nettype wire

// ==== tb.f ====
design/tdd_pkg.sv
design/tdd_ctrl_regs.sv
design/tdd_channel_bank.sv
design/tdd_read_mux.sv
design/tdd_regmap.sv
tests/tdd_regmap_asserts.sv
tests/tdd_regmap_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the register map testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tdd_regmap_tb -f tb.f --Mdir obj_dir -o tdd_regmap_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tdd_regmap_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qxF "Done: no errors"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
